// ==== src/sample_buffer_pkg.sv ====
package sample_buffer_pkg;

  localparam int sample_width      = 16;
  localparam int sample_depth_log2 = 10;
  localparam int sample_depth      = 1 << sample_depth_log2;
  localparam int host_addr_width   = 12;

  typedef logic [sample_width-1:0]      sample_t;
  typedef logic [sample_depth_log2-1:0] sample_addr_t;
  typedef logic [host_addr_width-1:0]   host_addr_t;

  // Register map, valid while host address bit 11 is clear.
  localparam host_addr_t reg_control = 12'd0;
  localparam host_addr_t reg_start   = 12'd1;
  localparam host_addr_t reg_end     = 12'd2;
  localparam host_addr_t reg_status  = 12'd3;
  localparam host_addr_t reg_wptr    = 12'd4;

  localparam int host_mem_sel_bit = host_addr_width - 1;

  typedef struct packed {
    logic         active;
    logic         one_shot;
    sample_addr_t start_offset;
    sample_addr_t end_offset;
  } capture_cfg_t;

  typedef struct packed {
    logic         enabled;
    logic         wrap_toggle;
    sample_addr_t wptr;
  } capture_status_t;

  typedef struct packed {
    logic         req;
    logic         we;
    sample_addr_t addr;
    sample_t      wdata;
  } mem_req_t;

  typedef enum logic [1:0] {
    arb_idle,
    arb_host_pending,
    arb_read_return
  } arb_state_t;

endpackage

// ==== src/sample_buffer_csr.sv ====
`timescale 1ns/100ps

module sample_buffer_csr import sample_buffer_pkg::*; (
  input  logic            stream_in,
  input  logic            rst_n,
  input  logic            host_wr,
  input  logic            host_rd,
  input  host_addr_t      host_addr,
  input  sample_t         host_wdata,
  output sample_t         host_rdata,
  output logic            host_rd_valid,
  output logic            host_busy,
  output capture_cfg_t    cfg,
  output logic            cfg_update,
  input  capture_status_t status,
  output mem_req_t        host_req,
  input  logic            host_grant,
  input  logic            host_rdata_valid,
  input  sample_t         mem_rdata
);

  logic    mem_sel;
  logic    reg_rd_valid;
  sample_t reg_rdata;
  sample_t reg_rdata_next;

  assign mem_sel = host_addr[host_mem_sel_bit];

  always_comb begin
    case (host_addr)
      reg_control: reg_rdata_next = sample_t'({cfg.one_shot, cfg.active});
      reg_start:   reg_rdata_next = sample_t'(cfg.start_offset);
      reg_end:     reg_rdata_next = sample_t'(cfg.end_offset);
      reg_status:  reg_rdata_next = sample_t'({status.wrap_toggle, status.enabled});
      reg_wptr:    reg_rdata_next = sample_t'(status.wptr);
      default:     reg_rdata_next = '0;
    endcase
  end

  always_ff @(posedge stream_in) begin
    if (!rst_n) begin
      cfg        <= '0;
      cfg_update <= 1'b0;
    end else begin
      cfg_update <= host_wr && !mem_sel && (host_addr == reg_control);
      if (host_wr && !mem_sel) begin
        case (host_addr)
          reg_control: begin
            cfg.active   <= host_wdata[0];
            cfg.one_shot <= host_wdata[1];
          end
          reg_start: cfg.start_offset <= sample_addr_t'(host_wdata);
          reg_end:   cfg.end_offset   <= sample_addr_t'(host_wdata);
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge stream_in) begin
    if (!rst_n) begin
      reg_rd_valid <= 1'b0;
    end else begin
      reg_rd_valid <= host_rd && !mem_sel;
    end
    reg_rdata <= reg_rdata_next;
  end

  // The memory request stays up until the arbiter grants it.
  always_ff @(posedge stream_in) begin
    if (!rst_n) begin
      host_req.req <= 1'b0;
      host_busy    <= 1'b0;
    end else if ((host_wr || host_rd) && mem_sel) begin
      host_req.req   <= 1'b1;
      host_req.we    <= host_wr;
      host_req.addr  <= sample_addr_t'(host_addr);
      host_req.wdata <= host_wdata;
      host_busy      <= 1'b1;
    end else begin
      if (host_grant) begin
        host_req.req <= 1'b0;
        if (host_req.we) host_busy <= 1'b0; // Writes are done once granted.
      end
      if (host_rdata_valid) host_busy <= 1'b0;
    end
  end

  assign host_rd_valid = reg_rd_valid | host_rdata_valid;
  assign host_rdata    = host_rdata_valid ? mem_rdata : reg_rdata;

endmodule

// ==== src/capture_engine.sv ====
`timescale 1ns/100ps

module capture_engine import sample_buffer_pkg::*; (
  input  logic            stream_in,
  input  logic            rst_n,
  input  logic            sample_valid,
  input  sample_t         sample_data,
  output logic            sample_ready,
  input  capture_cfg_t    cfg,
  input  logic            cfg_update,
  output capture_status_t status,
  output mem_req_t        capture_req
);

  logic         enabled;
  logic         wrap_toggle;
  sample_addr_t wptr;
  logic         write_en;
  logic         at_end;

  assign sample_ready = enabled;
  assign write_en     = sample_valid & enabled;
  assign at_end       = (wptr >= cfg.end_offset);

  always_ff @(posedge stream_in) begin
    if (!rst_n) begin
      enabled <= 1'b0;
    end else if (cfg_update) begin
      enabled <= cfg.active;
    end else if (cfg.one_shot && at_end) begin
      enabled <= 1'b0; // Stop one cycle after the last slot is reached.
    end
  end

  always_ff @(posedge stream_in) begin
    if (!rst_n) begin
      wptr        <= '0;
      wrap_toggle <= 1'b0;
    end else if (cfg_update && cfg.active) begin
      wptr <= cfg.start_offset;
    end else if (write_en) begin
      if (at_end) begin
        wptr        <= cfg.start_offset;
        wrap_toggle <= ~wrap_toggle;
      end else begin
        wptr <= wptr + 1'b1;
      end
    end
  end

  assign status = '{enabled: enabled, wrap_toggle: wrap_toggle, wptr: wptr};

  assign capture_req = '{
    req:   write_en,
    we:    1'b1,
    addr:  wptr,
    wdata: sample_data
  };

endmodule

// ==== src/memory_arbiter.sv ====
`timescale 1ns/100ps

module memory_arbiter import sample_buffer_pkg::*; (
  input  logic     stream_in,
  input  logic     rst_n,
  input  mem_req_t capture_req,
  input  mem_req_t host_req,
  output logic     host_grant,
  output logic     host_rdata_valid,
  output mem_req_t ram_req
);

  arb_state_t state;
  arb_state_t state_next;

  // Capture always wins; the host only gets cycles the stream leaves free.
  assign host_grant = host_req.req && !capture_req.req && (state != arb_read_return);

  always_comb begin
    ram_req = capture_req;
    if (host_grant) ram_req = host_req;
  end

  always_comb begin
    state_next = state;
    case (state)
      arb_idle, arb_host_pending: begin
        if (host_grant) begin
          state_next = host_req.we ? arb_idle : arb_read_return;
        end else if (host_req.req) begin
          state_next = arb_host_pending;
        end else begin
          state_next = arb_idle;
        end
      end
      arb_read_return: state_next = arb_idle;
      default: state_next = arb_idle;
    endcase
  end

  always_ff @(posedge stream_in) begin
    if (!rst_n) begin
      state <= arb_idle;
    end else begin
      state <= state_next;
    end
  end

  assign host_rdata_valid = (state == arb_read_return); // RAM output is valid now.

endmodule

// ==== src/sample_ram.sv ====
`timescale 1ns/100ps

module sample_ram import sample_buffer_pkg::*; (
  input  logic     stream_in,
  input  mem_req_t ram_req,
  output sample_t  mem_rdata
);

  sample_t mem [sample_depth];

  always_ff @(posedge stream_in) begin
    if (ram_req.req && ram_req.we) begin
      mem[ram_req.addr] <= ram_req.wdata;
    end else begin
      mem_rdata <= mem[ram_req.addr]; // Data appears one cycle later.
    end
  end

endmodule

// ==== src/sample_buffer.sv ====
`timescale 1ns/100ps

module sample_buffer import sample_buffer_pkg::*; (
  input  logic       stream_in,
  input  logic       rst_n,
  input  logic       sample_valid,
  input  sample_t    sample_data,
  output logic       sample_ready,
  input  logic       host_wr,
  input  logic       host_rd,
  input  host_addr_t host_addr,
  input  sample_t    host_wdata,
  output sample_t    host_rdata,
  output logic       host_rd_valid,
  output logic       host_busy
);

  capture_cfg_t    cfg;
  logic            cfg_update;
  capture_status_t status;
  mem_req_t        capture_req;
  mem_req_t        host_req;
  mem_req_t        ram_req;
  logic            host_grant;
  logic            host_rdata_valid;
  sample_t         mem_rdata;

  sample_buffer_csr i_csr (
    .stream_in        (stream_in),
    .rst_n            (rst_n),
    .host_wr          (host_wr),
    .host_rd          (host_rd),
    .host_addr        (host_addr),
    .host_wdata       (host_wdata),
    .host_rdata       (host_rdata),
    .host_rd_valid    (host_rd_valid),
    .host_busy        (host_busy),
    .cfg              (cfg),
    .cfg_update       (cfg_update),
    .status           (status),
    .host_req         (host_req),
    .host_grant       (host_grant),
    .host_rdata_valid (host_rdata_valid),
    .mem_rdata        (mem_rdata)
  );

  capture_engine i_capture (
    .stream_in    (stream_in),
    .rst_n        (rst_n),
    .sample_valid (sample_valid),
    .sample_data  (sample_data),
    .sample_ready (sample_ready),
    .cfg          (cfg),
    .cfg_update   (cfg_update),
    .status       (status),
    .capture_req  (capture_req)
  );

  memory_arbiter i_arbiter (
    .stream_in        (stream_in),
    .rst_n            (rst_n),
    .capture_req      (capture_req),
    .host_req         (host_req),
    .host_grant       (host_grant),
    .host_rdata_valid (host_rdata_valid),
    .ram_req          (ram_req)
  );

  sample_ram i_ram (
    .stream_in (stream_in),
    .ram_req   (ram_req),
    .mem_rdata (mem_rdata)
  );

endmodule

// ==== test/sample_buffer_asserts.sv ====
`timescale 1ns/100ps

module sample_buffer_asserts import sample_buffer_pkg::*; (
  input logic     stream_in,
  input logic     rst_n,
  input logic     sample_valid,
  input logic     sample_ready,
  input sample_t  sample_data,
  input logic     host_rd_valid,
  input logic     host_busy,
  input logic     host_rdata_valid,
  input logic     host_grant,
  input mem_req_t ram_req
);

  // A register read answers only while no memory access is in flight.
  assert property (@(posedge stream_in) disable iff (!rst_n)
    (host_rd_valid && !host_rdata_valid) |-> !host_busy)
    else $error("register read returned while host_busy was high");

  assert property (@(posedge stream_in) !rst_n |=> !sample_ready)
    else $error("sample_ready high in the cycle after reset");

  // Every accepted sample reaches the RAM in its own cycle, never beside a host grant.
  assert property (@(posedge stream_in) disable iff (!rst_n)
    (sample_valid && sample_ready) |->
      (!host_grant && ram_req.req && ram_req.we && (ram_req.wdata == sample_data)))
    else $error("capture write delayed or granted together with a host access");

endmodule

bind sample_buffer sample_buffer_asserts i_asserts (
  .stream_in        (stream_in),
  .rst_n            (rst_n),
  .sample_valid     (sample_valid),
  .sample_ready     (sample_ready),
  .sample_data      (sample_data),
  .host_rd_valid    (host_rd_valid),
  .host_busy        (host_busy),
  .host_rdata_valid (host_rdata_valid),
  .host_grant       (host_grant),
  .ram_req          (ram_req)
);

// ==== test/sample_buffer_tb.sv ====
`timescale 1ns/100ps

module sample_buffer_tb import sample_buffer_pkg::*; ();

  localparam int cycle_limit = 20000; // The directed sequences need under 2000 cycles.

  logic       stream_in;
  logic       rst_n;
  logic       sample_valid;
  sample_t    sample_data;
  logic       sample_ready;
  logic       host_wr;
  logic       host_rd;
  host_addr_t host_addr;
  sample_t    host_wdata;
  sample_t    host_rdata;
  logic       host_rd_valid;
  logic       host_busy;

  int           errors = 0;
  int           cycles = 0;
  integer       seed   = 32'hb588;
  int           accepted_total;
  sample_t      next_data;
  sample_t      model_mem [sample_depth];
  sample_addr_t model_ptr;
  sample_addr_t model_start;
  sample_addr_t model_end;
  logic         model_toggle;

  sample_buffer i_dut (.*);

  initial begin
    stream_in = 1'b0;
    forever #5 stream_in = ~stream_in;
  end

  always @(posedge stream_in) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Error: run stopped after %0d cycles, the DUT never finished", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic next_cycle();
    @(posedge stream_in);
    #1; // Inputs change just after the edge.
  endtask

  task automatic report_error(string msg);
    errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic check_sample(string name, sample_t expected, sample_t actual);
    if (actual !== expected) begin
      errors++;
      $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_addr(string name, sample_addr_t expected, sample_addr_t actual);
    if (actual !== expected) begin
      errors++;
      $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_status(string name, capture_status_t expected, capture_status_t actual);
    if (actual !== expected) begin
      errors++;
      $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  function automatic host_addr_t mem_addr(sample_addr_t addr);
    return {1'b1, 1'b0, addr}; // Bit 11 selects the sample memory.
  endfunction

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (3) @(posedge stream_in);
    #1;
    rst_n        = 1'b1;
    model_ptr    = '0;
    model_toggle = 1'b0;
  endtask

  task automatic host_write(host_addr_t addr, sample_t data);
    while (host_busy) next_cycle();
    host_wr    = 1'b1;
    host_addr  = addr;
    host_wdata = data;
    next_cycle();
    host_wr = 1'b0;
    if (host_busy !== addr[host_mem_sel_bit]) begin
      report_error("host_busy after a write strobe does not match the access type");
    end
    while (host_busy) next_cycle();
  endtask

  task automatic host_read(host_addr_t addr, output sample_t data);
    int latency;
    while (host_busy) next_cycle();
    host_rd   = 1'b1;
    host_addr = addr;
    next_cycle();
    host_rd = 1'b0;
    latency = 1;
    if (host_busy !== addr[host_mem_sel_bit]) begin
      report_error("host_busy after a read strobe does not match the access type");
    end
    while (!host_rd_valid) begin
      next_cycle();
      latency++;
    end
    if (addr[host_mem_sel_bit] ? (latency < 2) : (latency != 1)) begin
      report_error($sformatf("read of address %h answered after %0d cycles", addr, latency));
    end
    data = host_rdata;
  endtask

  task automatic write_word(sample_addr_t addr, sample_t data);
    host_write(mem_addr(addr), data);
    model_mem[addr] = data;
  endtask

  task automatic verify_range(sample_addr_t first, sample_addr_t last);
    sample_t data;
    for (sample_addr_t a = first; a <= last; a++) begin
      host_read(mem_addr(a), data);
      check_sample($sformatf("mem[%0d]", a), model_mem[a], data);
    end
  endtask

  task automatic verify_status(logic enabled);
    sample_t         st;
    sample_t         wp;
    capture_status_t expected;
    capture_status_t actual;
    host_read(reg_status, st);
    host_read(reg_wptr, wp);
    expected = '{enabled: enabled, wrap_toggle: model_toggle, wptr: model_ptr};
    actual   = '{enabled: st[0], wrap_toggle: st[1], wptr: sample_addr_t'(wp)};
    check_status("status", expected, actual);
  endtask

  task automatic start_capture(sample_addr_t start_off, sample_addr_t end_off, logic one_shot);
    host_write(reg_start, sample_t'(start_off));
    host_write(reg_end, sample_t'(end_off));
    host_write(reg_control, {14'd0, one_shot, 1'b1});
    model_start = start_off;
    model_end   = end_off;
    model_ptr   = start_off;
  endtask

  // Sends until count samples are taken, and mirrors each write into the model.
  task automatic send_samples(int count, bit gaps);
    int   sent;
    logic accept;
    sent = 0;
    while (sent < count) begin
      sample_valid = gaps ? (($random(seed) & 3) != 0) : 1'b1;
      sample_data  = next_data;
      accept       = sample_valid && sample_ready;
      next_cycle();
      if (accept) begin
        model_mem[model_ptr] = next_data;
        if (model_ptr >= model_end) begin
          model_ptr    = model_start;
          model_toggle = ~model_toggle;
        end else begin
          model_ptr = model_ptr + 10'd1;
        end
        next_data++;
        sent++;
        accepted_total++;
      end
    end
    sample_valid = 1'b0;
  endtask

  task automatic hold_valid(int count);
    for (int i = 0; i < count; i++) begin
      sample_valid = 1'b1;
      sample_data  = 16'hdead;
      if (sample_ready) report_error("stream sample accepted while capture is stopped");
      next_cycle();
    end
    sample_valid = 1'b0;
  endtask

  task automatic read_during_capture(int reads);
    sample_t      data;
    sample_addr_t addr;
    for (int k = 0; k < reads; k++) begin
      while (accepted_total <= 3 * k) next_cycle();
      addr = model_start + sample_addr_t'(3 * k);
      host_read(mem_addr(addr), data);
      check_sample($sformatf("mem[%0d] under capture", addr), model_mem[addr], data);
    end
  endtask

  task automatic run_register_test();
    sample_t data;
    verify_status(1'b0);
    host_write(reg_start, 16'h0155);
    host_write(reg_end, 16'h02aa);
    host_read(reg_start, data);
    check_addr("reg_start", 10'h155, sample_addr_t'(data));
    host_read(reg_end, data);
    check_addr("reg_end", 10'h2aa, sample_addr_t'(data));
  endtask

  task automatic run_one_shot_test();
    write_word(10'd9, 16'ha009);
    write_word(10'd42, 16'ha02a);
    start_capture(10'd10, 10'd41, 1'b1);
    send_samples(32, 1'b0);
    hold_valid(4);
    verify_status(1'b0);
    verify_range(10'd9, 10'd42);
  endtask

  task automatic run_wrap_test();
    apply_reset();
    start_capture(10'd100, 10'd107, 1'b0);
    send_samples(20, 1'b0);
    verify_status(1'b1);
    verify_range(10'd100, 10'd107);
  endtask

  task automatic run_stop_test();
    host_write(reg_control, 16'h0000);
    next_cycle(); // Enable follows the update pulse by one edge.
    hold_valid(6);
    verify_status(1'b0);
    verify_range(10'd100, 10'd107);
  endtask

  task automatic run_contention_test();
    start_capture(10'd200, 10'd455, 1'b0);
    accepted_total = 0;
    fork
      send_samples(120, 1'b1);
      read_during_capture(30);
    join
    verify_status(1'b1);
    verify_range(10'd200, 10'd319);
  endtask

  initial begin
    rst_n        = 1'b0;
    sample_valid = 1'b0;
    sample_data  = '0;
    host_wr      = 1'b0;
    host_rd      = 1'b0;
    host_addr    = '0;
    host_wdata   = '0;
    next_data    = 16'h1000;
    apply_reset();
    run_register_test();
    run_one_shot_test();
    run_wrap_test();
    run_stop_test();
    run_contention_test();
    $display("Run ended after %0d cycles with %0d errors", cycles, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
src/sample_buffer_pkg.sv
src/sample_buffer_csr.sv
src/capture_engine.sv
src/memory_arbiter.sv
src/sample_ram.sv
src/sample_buffer.sv
test/sample_buffer_asserts.sv
test/sample_buffer_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module sample_buffer_tb

if ! ./obj_dir/Vsample_buffer_tb > sim.log 2>&1; then
  cat sim.log
  exit 1
fi
cat sim.log

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
